//--- Bender.yml
package:
  name: frame_checksum

sources:
  - logic/fletcherPkg.sv
  - logic/fletcherSum.sv
  - logic/frameChecker.sv
  - logic/checksumRegs.sv
  - logic/frameChecksumUnit.sv
  - target: test
    files:
      - verification/frameChecksumTb.sv

//--- logic/checksumRegs.sv
module checksumRegs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    regWrite,
    input  logic                    regRead,
    input  fletcherPkg::regAddr_t   regAddr,
    input  fletcherPkg::regData_t   regWrData,
    output fletcherPkg::regData_t   regRdData,
    output logic                    enable,
    output fletcherPkg::checksum_t  expected,
    input  logic                    resultStrobe,
    input  logic                    resultMatch,
    input  fletcherPkg::checksum_t  resultSum
);

    fletcherPkg::count_t goodCount;
    fletcherPkg::count_t badCount;
    fletcherPkg::checksum_t lastSum;
    fletcherPkg::regData_t readMux;
    logic writeControl;
    logic writeExpected;
    logic clearCounts;

    assign writeControl = regWrite && (regAddr == fletcherPkg::AddrControl);
    assign writeExpected = regWrite && (regAddr == fletcherPkg::AddrExpected);
    assign clearCounts = regWrite && (regAddr == fletcherPkg::AddrCounts);

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            expected <= '0;
        end else begin
            if (writeControl) begin
                enable <= regWrData[0];
            end
            if (writeExpected) begin
                expected <= regWrData;
            end
        end
    end

    // A clear in the same cycle as a result wins
    always_ff @(posedge clk) begin
        if (rst) begin
            goodCount <= '0;
            badCount <= '0;
        end else if (clearCounts) begin
            goodCount <= '0;
            badCount <= '0;
        end else if (resultStrobe) begin
            if (resultMatch) begin
                if (goodCount != fletcherPkg::CountMax) begin
                    goodCount <= goodCount + 1'b1;
                end
            end else begin
                if (badCount != fletcherPkg::CountMax) begin
                    badCount <= badCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lastSum <= '0;
        end else if (resultStrobe) begin
            lastSum <= resultSum;
        end
    end

    always_comb begin
        case (regAddr)
            fletcherPkg::AddrControl: begin
                readMux = {{(fletcherPkg::RegWidth-1){1'b0}}, enable};
            end
            fletcherPkg::AddrExpected: begin
                readMux = expected;
            end
            fletcherPkg::AddrCounts: begin
                readMux = {badCount, goodCount};    // Bad count in the upper half
            end
            default: begin
                readMux = lastSum;
            end
        endcase
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            regRdData <= '0;
        end else if (regRead) begin
            regRdData <= readMux;
        end
    end

endmodule

//--- logic/fletcherPkg.sv
package fletcherPkg;

    localparam int WordWidth = 16;
    localparam int SumWidth = 32;
    localparam int AddrWidth = 2;
    localparam int RegWidth = 32;
    localparam int CountWidth = 16;

    typedef logic [WordWidth-1:0] dataWord_t;   // One input word or one half-sum
    typedef logic [SumWidth-1:0] checksum_t;    // High half b, low half a
    typedef logic [AddrWidth-1:0] regAddr_t;
    typedef logic [RegWidth-1:0] regData_t;
    typedef logic [CountWidth-1:0] count_t;

    // 65535 on the 17-bit adder path
    localparam logic [WordWidth:0] Modulus = {1'b0, {WordWidth{1'b1}}};

    // Saturation point of the frame counters
    localparam count_t CountMax = '1;

    localparam regAddr_t AddrControl = 2'd0;    // Bit 0 is enable
    localparam regAddr_t AddrExpected = 2'd1;   // Expected checksum
    localparam regAddr_t AddrCounts = 2'd2;     // {bad, good}, write clears
    localparam regAddr_t AddrLastSum = 2'd3;    // Last computed checksum

    typedef enum logic [1:0] {
        Idle,
        Collect,
        Settle,
        Compare
    } checkState_t;

endpackage

//--- logic/fletcherSum.sv
module fletcherSum (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sumEn,
    input  logic                    sumClear,
    input  fletcherPkg::dataWord_t  sumData,
    output fletcherPkg::checksum_t  sumOut
);

    fletcherPkg::dataWord_t sumA;
    fletcherPkg::dataWord_t sumB;
    logic sumEnDly;                 // High half trails the low half by one edge

    logic [fletcherPkg::WordWidth:0] addA;
    logic [fletcherPkg::WordWidth:0] subA;
    logic [fletcherPkg::WordWidth:0] addB;
    logic [fletcherPkg::WordWidth:0] subB;
    fletcherPkg::dataWord_t nextA;
    fletcherPkg::dataWord_t nextB;

    // A borrow out of the subtraction means the raw sum is already below 65535
    assign addA = {1'b0, sumA} + {1'b0, sumData};
    assign subA = addA - fletcherPkg::Modulus;
    assign nextA = subA[fletcherPkg::WordWidth] ? addA[fletcherPkg::WordWidth-1:0]
                                                : subA[fletcherPkg::WordWidth-1:0];

    assign addB = {1'b0, sumB} + {1'b0, sumA};  // Uses the already updated a
    assign subB = addB - fletcherPkg::Modulus;
    assign nextB = subB[fletcherPkg::WordWidth] ? addB[fletcherPkg::WordWidth-1:0]
                                                : subB[fletcherPkg::WordWidth-1:0];

    always_ff @(posedge clk) begin
        if (rst || sumClear) begin
            sumA <= '0;
            sumB <= '0;
            sumEnDly <= 1'b0;
        end else begin
            sumEnDly <= sumEn;
            if (sumEn) begin
                sumA <= nextA;
            end
            if (sumEnDly) begin
                sumB <= nextB;
            end
        end
    end

    assign sumOut = {sumB, sumA};

endmodule

//--- logic/frameChecker.sv
module frameChecker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  logic                    frameValid,
    input  logic                    frameLast,
    input  fletcherPkg::dataWord_t  frameData,
    input  fletcherPkg::checksum_t  expected,
    input  fletcherPkg::checksum_t  sumOut,
    output logic                    sumEn,
    output logic                    sumClear,
    output fletcherPkg::dataWord_t  sumData,
    output logic                    frameDone,
    output logic                    frameMatch,
    output logic                    resultStrobe,
    output logic                    resultMatch,
    output fletcherPkg::checksum_t  resultSum
);

    fletcherPkg::checkState_t state;
    fletcherPkg::checkState_t nextState;
    logic acceptWord;
    logic inCompare;
    logic sumsEqual;

    // Enable only matters for the first word of a frame
    always_comb begin
        acceptWord = 1'b0;
        nextState = state;
        case (state)
            fletcherPkg::Idle: begin
                if (frameValid && enable) begin
                    acceptWord = 1'b1;
                    if (frameLast) begin
                        nextState = fletcherPkg::Settle;    // One-word frame
                    end else begin
                        nextState = fletcherPkg::Collect;
                    end
                end
            end
            fletcherPkg::Collect: begin
                if (frameValid) begin
                    acceptWord = 1'b1;
                    if (frameLast) begin
                        nextState = fletcherPkg::Settle;
                    end
                end
            end
            fletcherPkg::Settle: begin
                nextState = fletcherPkg::Compare;   // High half lands here
            end
            fletcherPkg::Compare: begin
                nextState = fletcherPkg::Idle;
            end
            default: begin
                nextState = fletcherPkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fletcherPkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    // Words in Settle or Compare never reach the sums
    assign sumEn = acceptWord;
    assign sumData = frameData;

    assign inCompare = (state == fletcherPkg::Compare);
    assign sumsEqual = (sumOut == expected);

    assign frameDone = inCompare;
    assign frameMatch = inCompare && sumsEqual;

    // Register side sees the same pulse as the outside world
    assign resultStrobe = inCompare;
    assign resultMatch = sumsEqual;
    assign resultSum = sumOut;

    assign sumClear = inCompare;    // Ready for the next frame in Idle

endmodule

//--- logic/frameChecksumUnit.sv
module frameChecksumUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frameValid,
    input  logic                    frameLast,
    input  fletcherPkg::dataWord_t  frameData,
    input  logic                    regWrite,
    input  logic                    regRead,
    input  fletcherPkg::regAddr_t   regAddr,
    input  fletcherPkg::regData_t   regWrData,
    output fletcherPkg::regData_t   regRdData,
    output logic                    frameDone,
    output logic                    frameMatch
);

    logic enable;
    fletcherPkg::checksum_t expected;

    logic resultStrobe;
    logic resultMatch;
    fletcherPkg::checksum_t resultSum;

    logic sumEn;
    logic sumClear;
    fletcherPkg::dataWord_t sumData;
    fletcherPkg::checksum_t sumOut;

    checksumRegs checksumRegs_inst (
        .clk          (clk),
        .rst          (rst),
        .regWrite     (regWrite),
        .regRead      (regRead),
        .regAddr      (regAddr),
        .regWrData    (regWrData),
        .regRdData    (regRdData),
        .enable       (enable),
        .expected     (expected),
        .resultStrobe (resultStrobe),
        .resultMatch  (resultMatch),
        .resultSum    (resultSum)
    );

    frameChecker frameChecker_inst (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .frameValid   (frameValid),
        .frameLast    (frameLast),
        .frameData    (frameData),
        .expected     (expected),
        .sumOut       (sumOut),
        .sumEn        (sumEn),
        .sumClear     (sumClear),
        .sumData      (sumData),
        .frameDone    (frameDone),
        .frameMatch   (frameMatch),
        .resultStrobe (resultStrobe),
        .resultMatch  (resultMatch),
        .resultSum    (resultSum)
    );

    fletcherSum fletcherSum_inst (
        .clk      (clk),
        .rst      (rst),
        .sumEn    (sumEn),
        .sumClear (sumClear),
        .sumData  (sumData),
        .sumOut   (sumOut)
    );

endmodule

//--- sources.f
logic/fletcherPkg.sv
logic/fletcherSum.sv
logic/frameChecker.sv
logic/checksumRegs.sv
logic/frameChecksumUnit.sv
verification/frameChecksumTb.sv

//--- verification/frameChecksumTb.sv
module frameChecksumTb;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 16;
    localparam int MaxLen = 40;
    localparam int MaxGap = 6;
    localparam int NumDirected = 3;
    localparam int NumRandom = 30;
    localparam int NumAfterClear = 4;
    localparam int NumDisabled = 3;
    localparam int NumResumed = 5;
    localparam int NumFrames = NumDirected + NumRandom + NumAfterClear + NumDisabled + NumResumed;
    // Expected write, settle, done, two reads and the longest gap on top of the words
    localparam int MaxFrameCycles = MaxLen + MaxGap + 12;
    localparam int WatchdogTime = (ResetCycles + NumFrames * MaxFrameCycles + 200) * ClkPeriod;

    logic clk;
    logic rst;
    logic frameValid;
    logic frameLast;
    fletcherPkg::dataWord_t frameData;
    logic regWrite;
    logic regRead;
    fletcherPkg::regAddr_t regAddr;
    fletcherPkg::regData_t regWrData;
    fletcherPkg::regData_t regRdData;
    logic frameDone;
    logic frameMatch;

    logic [31:0] rngState;
    fletcherPkg::dataWord_t frameWords[$];
    fletcherPkg::count_t goodModel;
    fletcherPkg::count_t badModel;
    logic [31:0] lastModelSum;
    int errorCount;
    int checkCount;

    frameChecksumUnit frameChecksumUnit_inst (
        .clk        (clk),
        .rst        (rst),
        .frameValid (frameValid),
        .frameLast  (frameLast),
        .frameData  (frameData),
        .regWrite   (regWrite),
        .regRead    (regRead),
        .regAddr    (regAddr),
        .regWrData  (regWrData),
        .regRdData  (regRdData),
        .frameDone  (frameDone),
        .frameMatch (frameMatch)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Fletcher-32 over the queued frame, both halves kept in 0..65534
    function automatic logic [31:0] modelChecksum();
        int a;
        int b;
        a = 0;
        b = 0;
        foreach (frameWords[i]) begin
            a = (a + frameWords[i]) % 65535;
            b = (b + a) % 65535;
        end
        return {b[15:0], a[15:0]};
    endfunction

    task automatic pickRange(input int lo, input int hi, output int value);
        rngState = xorshift(rngState);
        value = lo + int'(rngState % (hi - lo + 1));
    endtask

    task automatic checkValue(input string name, input logic [31:0] expectedVal,
                              input logic [31:0] actualVal);
        checkCount++;
        if (actualVal !== expectedVal) begin
            errorCount++;
            $display("error at time %0t: %s expected %h actual %h", $time, name,
                     expectedVal, actualVal);
        end
    endtask

    task automatic noteFailure(input string msg);
        errorCount++;
        $display("Failure at time %0t: %s", $time, msg);
    endtask

    task automatic idleInputs();
        frameValid = 1'b0;
        frameLast = 1'b0;
        frameData = '0;
        regWrite = 1'b0;
        regRead = 1'b0;
    endtask

    // Tasks start just after a falling edge and end on one with the inputs idle
    task automatic writeReg(input fletcherPkg::regAddr_t addr, input logic [31:0] data);
        regWrite = 1'b1;
        regAddr = addr;
        regWrData = data;
        @(negedge clk);
        idleInputs();
    endtask

    task automatic readReg(input fletcherPkg::regAddr_t addr, output logic [31:0] data);
        regRead = 1'b1;
        regAddr = addr;
        @(negedge clk);
        idleInputs();
        data = regRdData;   // Registered one cycle after the request
    endtask

    task automatic buildRandomFrame();
        int len;
        pickRange(1, MaxLen, len);
        frameWords.delete();
        repeat (len) begin
            rngState = xorshift(rngState);
            if (rngState[31:29] == 3'd0) begin
                frameWords.push_back(16'hFFFF);     // Lands exactly on the modulus
            end else begin
                frameWords.push_back(rngState[15:0]);
            end
        end
    endtask

    task automatic loadDirected(input int which);
        frameWords.delete();
        case (which)
            0: frameWords = '{16'hFFFF};                // a reduces to 0
            1: frameWords = '{16'hFFFE, 16'h0001};      // a hits 65535 on the second word
            default: frameWords = '{16'h0001, 16'hFFFD}; // b hits 65535
        endcase
    endtask

    task automatic driveWords();
        foreach (frameWords[i]) begin
            frameValid = 1'b1;
            frameData = frameWords[i];
            frameLast = (i == frameWords.size() - 1);
            @(negedge clk);
        end
        idleInputs();
    endtask

    task automatic driveJunk();
        rngState = xorshift(rngState);
        frameValid = 1'b1;
        frameData = rngState[15:0];
        frameLast = rngState[16];
    endtask

    task automatic checkFrame(input bit junkAfter);
        logic [31:0] sum;
        logic [31:0] expectedVal;
        logic [31:0] readData;
        logic isMatch;
        int gap;
        sum = modelChecksum();
        rngState = xorshift(rngState);
        isMatch = rngState[0];
        expectedVal = isMatch ? sum : (sum ^ (rngState | 32'h1));
        writeReg(fletcherPkg::AddrExpected, expectedVal);
        driveWords();
        checkValue("frameDone", 1'b0, frameDone);
        if (junkAfter) begin
            driveJunk();    // Lands in Settle
        end
        @(negedge clk);
        if (frameDone !== 1'b1) begin
            noteFailure("frameDone did not pulse two cycles after the last word");
        end
        checkValue("frameMatch", isMatch, frameMatch);
        if (junkAfter) begin
            driveJunk();    // Lands in Compare
        end
        @(negedge clk);
        idleInputs();
        checkValue("frameDone", 1'b0, frameDone);
        lastModelSum = sum;
        if (isMatch && goodModel != 16'hFFFF) begin
            goodModel++;
        end else if (!isMatch && badModel != 16'hFFFF) begin
            badModel++;
        end
        readReg(fletcherPkg::AddrLastSum, readData);
        checkValue("lastSum", sum, readData);
        readReg(fletcherPkg::AddrCounts, readData);
        checkValue("counts", {badModel, goodModel}, readData);
        pickRange(3, MaxGap, gap);
        repeat (gap) @(negedge clk);
    endtask

    task automatic checkDisabledFrame();
        logic [31:0] readData;
        buildRandomFrame();
        driveWords();
        repeat (3) begin
            checkValue("frameDone", 1'b0, frameDone);
            @(negedge clk);
        end
        readReg(fletcherPkg::AddrCounts, readData);
        checkValue("counts", {badModel, goodModel}, readData);
        readReg(fletcherPkg::AddrLastSum, readData);
        checkValue("lastSum", lastModelSum, readData);
    endtask

    initial begin : stimulus
        logic [31:0] readData;
        rngState = 32'd13;
        goodModel = '0;
        badModel = '0;
        lastModelSum = '0;
        errorCount = 0;
        checkCount = 0;
        rst = 1'b1;
        regAddr = '0;
        regWrData = '0;
        idleInputs();
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        writeReg(fletcherPkg::AddrControl, 32'h1);
        for (int d = 0; d < NumDirected; d++) begin
            loadDirected(d);
            checkFrame(1'b0);
        end
        for (int n = 0; n < NumRandom; n++) begin
            buildRandomFrame();
            rngState = xorshift(rngState);
            checkFrame(rngState[3]);
        end
        writeReg(fletcherPkg::AddrCounts, 32'hFFFF_FFFF);   // Clears both counters whatever the data
        goodModel = '0;
        badModel = '0;
        readReg(fletcherPkg::AddrCounts, readData);
        checkValue("counts", 32'h0, readData);
        for (int n = 0; n < NumAfterClear; n++) begin
            buildRandomFrame();
            checkFrame(1'b1);
        end
        writeReg(fletcherPkg::AddrControl, 32'h0);
        for (int n = 0; n < NumDisabled; n++) begin
            checkDisabledFrame();
        end
        writeReg(fletcherPkg::AddrControl, 32'h1);
        for (int n = 0; n < NumResumed; n++) begin
            buildRandomFrame();
            checkFrame(1'b0);
        end
        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogTime);
        $display("Watchdog expired before all frames were checked");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
